// ==== isa_pkg.sv ====
package isa_pkg;

    // instruction opcodes
    typedef enum logic [7:0] {
        NO_OP       = 8'h00,
        ADD         = 8'h01,
        SUB         = 8'h02,
        AND         = 8'h03,
        OR          = 8'h04,
        NOT         = 8'h05,
        XOR         = 8'h06,
        RAND        = 8'h07,
        ROR         = 8'h08,
        RXOR        = 8'h09,
        LSL         = 8'h0A,
        LSR         = 8'h0B,
        ASL         = 8'h0C,
        ASR         = 8'h0D,
        CSL         = 8'h0E,
        CSR         = 8'h0F,
        INC         = 8'h10,
        DEC         = 8'h11,
        PUSH        = 8'hF9,
        POP         = 8'hFA,
        MOV_RA      = 8'hFD,
        MOV_AR      = 8'hFE,
        LOAD_MOV_RR = 8'hFF
    } opcode_t;

    typedef logic [4:0] reg_sel_t;

    localparam reg_sel_t SEL_NONE   = 5'd0;
    localparam reg_sel_t SEL_A      = 5'd1;
    localparam reg_sel_t SEL_B      = 5'd2;
    localparam reg_sel_t SEL_C      = 5'd3;
    localparam reg_sel_t SEL_D      = 5'd4;
    localparam reg_sel_t SEL_E      = 5'd5;
    localparam reg_sel_t SEL_F      = 5'd6;
    // R on reads, SS on writes
    localparam reg_sel_t SEL_R_SS   = 5'd7;
    // SP on writes, immediate data_i as ALU operand
    localparam reg_sel_t SEL_SP_IMM = 5'd8;

endpackage

// ==== dp_pkg.sv ====
package dp_pkg;

    localparam int WORD_W = 16;

    typedef logic [WORD_W-1:0] word_t;
    // result word plus carry bit
    typedef logic [WORD_W:0]   wide_t;
    typedef logic [3:0]        flag_t;

    // flag bit positions
    localparam int FLAG_OVF   = 0;
    localparam int FLAG_ZERO  = 1;
    localparam int FLAG_CARRY = 2;
    localparam int FLAG_STACK = 3;

    typedef enum logic [1:0] {
        STK_NONE,
        STK_PUSH,
        STK_POP
    } stack_op_t;

    typedef enum logic [1:0] {
        WR_NONE,
        WR_DATA,
        WR_COPY,
        WR_MEM
    } wr_src_t;

endpackage

// ==== ctrl_if.sv ====
`timescale 1ns/10ps

interface ctrl_if;

    logic                exec;
    isa_pkg::opcode_t    op;
    isa_pkg::reg_sel_t   sel_a;
    isa_pkg::reg_sel_t   sel_b;
    isa_pkg::reg_sel_t   sel_wr;
    dp_pkg::wr_src_t     wr_src;
    logic                out_en;
    logic                alu_en;
    dp_pkg::stack_op_t   stk_op;

    modport dec (
        output exec, op, sel_a, sel_b, sel_wr, wr_src, out_en, alu_en, stk_op
    );

    modport regs (
        input exec, sel_a, sel_b, sel_wr, wr_src, out_en, alu_en
    );

    modport alu (
        input exec, op, alu_en
    );

    modport stk (
        input exec, sel_wr, wr_src, stk_op
    );

endinterface

// ==== op_decoder.sv ====
`timescale 1ns/10ps

module op_decoder (
    input  logic              clk,
    input  logic              rst_ni,
    input  logic              req_i,
    output logic              ack_o,
    input  isa_pkg::opcode_t  op_i,
    input  isa_pkg::reg_sel_t sel1_i,
    input  isa_pkg::reg_sel_t sel2_i,
    ctrl_if.dec               ctrl
);

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        DONE
    } state_e;

    state_e            state_q;
    state_e            state_d;
    isa_pkg::opcode_t  op_q;
    isa_pkg::reg_sel_t sel1_q;
    isa_pkg::reg_sel_t sel2_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (req_i) state_d = EXEC;
            EXEC:    state_d = DONE;
            // wait here as long as the requester holds req high
            DONE:    if (!req_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            op_q    <= isa_pkg::NO_OP;
            sel1_q  <= isa_pkg::SEL_NONE;
            sel2_q  <= isa_pkg::SEL_NONE;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && req_i) begin
                op_q   <= op_i;
                sel1_q <= sel1_i;
                sel2_q <= sel2_i;
            end
        end
    end

    assign ack_o     = (state_q == DONE);
    assign ctrl.exec = (state_q == EXEC);

    always_comb begin
        ctrl.op     = op_q;
        ctrl.sel_a  = isa_pkg::SEL_NONE;
        ctrl.sel_b  = isa_pkg::SEL_NONE;
        ctrl.sel_wr = isa_pkg::SEL_NONE;
        ctrl.wr_src = dp_pkg::WR_NONE;
        ctrl.out_en = 1'b0;
        ctrl.alu_en = 1'b0;
        ctrl.stk_op = dp_pkg::STK_NONE;
        case (op_q)
            isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR: begin
                ctrl.alu_en = 1'b1;
                ctrl.sel_a  = sel1_q;
                ctrl.sel_b  = sel2_q;
            end
            isa_pkg::NOT, isa_pkg::RAND, isa_pkg::ROR, isa_pkg::RXOR,
            isa_pkg::LSL, isa_pkg::LSR, isa_pkg::ASL, isa_pkg::ASR,
            isa_pkg::CSL, isa_pkg::CSR, isa_pkg::INC, isa_pkg::DEC: begin
                ctrl.alu_en = 1'b1;
                ctrl.sel_a  = sel1_q;
            end
            isa_pkg::PUSH: begin
                ctrl.sel_a  = sel1_q;
                ctrl.stk_op = dp_pkg::STK_PUSH;
            end
            isa_pkg::POP: begin
                ctrl.sel_wr = sel1_q;
                ctrl.wr_src = dp_pkg::WR_MEM;
                ctrl.stk_op = dp_pkg::STK_POP;
            end
            isa_pkg::MOV_RA: begin
                ctrl.sel_a  = sel1_q;
                ctrl.out_en = 1'b1;
            end
            isa_pkg::MOV_AR: begin
                ctrl.sel_wr = sel2_q;
                ctrl.wr_src = dp_pkg::WR_DATA;
            end
            isa_pkg::LOAD_MOV_RR: begin
                ctrl.sel_a  = sel1_q;
                ctrl.sel_wr = sel2_q;
                ctrl.wr_src = dp_pkg::WR_COPY;
            end
            default: ;
        endcase
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/10ps

module reg_file #(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rst_ni,
    ctrl_if.regs              ctrl,
    input  logic [DATA_W-1:0] data_i,
    input  logic [DATA_W:0]   result_i,
    input  logic [DATA_W-1:0] pop_data_i,
    input  logic              pop_ok_i,
    output logic [DATA_W-1:0] operand_a_o,
    output logic [DATA_W-1:0] operand_b_o,
    output logic [DATA_W-1:0] push_data_o,
    output logic [DATA_W-1:0] data_o
);

    // A..F at index 0..5
    logic [DATA_W-1:0] gpr_q [6];
    logic [DATA_W-1:0] r_q;
    logic [DATA_W-1:0] rd_a;
    logic [DATA_W-1:0] wr_data;
    logic              wr_en;

    function automatic logic [DATA_W-1:0] read_sel(isa_pkg::reg_sel_t sel,
                                                   logic [DATA_W-1:0] imm);
        if (sel >= isa_pkg::SEL_A && sel <= isa_pkg::SEL_F)
            return gpr_q[3'(sel - isa_pkg::SEL_A)];
        else if (sel == isa_pkg::SEL_R_SS)
            return r_q;
        else if (sel == isa_pkg::SEL_SP_IMM)
            return imm;
        return '0;
    endfunction

    // immediate only applies to ALU operands
    always_comb begin
        rd_a        = read_sel(ctrl.sel_a, '0);
        operand_a_o = read_sel(ctrl.sel_a, data_i);
        operand_b_o = read_sel(ctrl.sel_b, data_i);
    end

    assign push_data_o = rd_a;

    always_comb begin
        wr_data = data_i;
        wr_en   = 1'b0;
        case (ctrl.wr_src)
            dp_pkg::WR_DATA: wr_en = 1'b1;
            dp_pkg::WR_COPY: begin
                wr_data = rd_a;
                wr_en   = 1'b1;
            end
            dp_pkg::WR_MEM: begin
                wr_data = pop_data_i;
                wr_en   = pop_ok_i;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < 6; i++) gpr_q[i] <= '0;
            r_q    <= '0;
            data_o <= '0;
        end else if (ctrl.exec) begin
            if (wr_en && ctrl.sel_wr >= isa_pkg::SEL_A && ctrl.sel_wr <= isa_pkg::SEL_F)
                gpr_q[3'(ctrl.sel_wr - isa_pkg::SEL_A)] <= wr_data;
            if (ctrl.alu_en)
                r_q <= result_i[DATA_W-1:0];
            if (ctrl.out_en)
                data_o <= rd_a;
        end
    end

endmodule

// ==== alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit #(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rst_ni,
    ctrl_if.alu               ctrl,
    input  logic [DATA_W-1:0] operand_a_i,
    input  logic [DATA_W-1:0] operand_b_i,
    output logic [DATA_W:0]   result_o,
    output logic [2:0]        flag_o
);

    localparam int MSB = DATA_W - 1;

    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W:0]   res;
    logic              ovf;

    assign a = operand_a_i;
    assign b = operand_b_i;

    always_comb begin
        res = '0;
        case (ctrl.op)
            isa_pkg::ADD:  res = {1'b0, a} + {1'b0, b};
            // top bit ends up as the borrow
            isa_pkg::SUB:  res = {1'b0, a} - {1'b0, b};
            isa_pkg::AND:  res = {1'b0, a & b};
            isa_pkg::OR:   res = {1'b0, a | b};
            isa_pkg::NOT:  res = {1'b0, ~a};
            isa_pkg::XOR:  res = {1'b0, a ^ b};
            isa_pkg::RAND: res = {{DATA_W{1'b0}}, &a};
            isa_pkg::ROR:  res = {{DATA_W{1'b0}}, |a};
            isa_pkg::RXOR: res = {{DATA_W{1'b0}}, ^a};
            isa_pkg::LSL:  res = {a, 1'b0};
            isa_pkg::ASL:  res = {a, 1'b0};
            isa_pkg::LSR:  res = {2'b00, a[MSB:1]};
            isa_pkg::ASR:  res = {1'b0, a[MSB], a[MSB:1]};
            isa_pkg::CSL:  res = {1'b0, a[MSB-1:0], a[MSB]};
            isa_pkg::CSR:  res = {1'b0, a[0], a[MSB:1]};
            isa_pkg::INC:  res = {1'b0, a + DATA_W'(1)};
            isa_pkg::DEC:  res = {1'b0, a - DATA_W'(1)};
            default:       res = '0;
        endcase
    end

    // signed overflow, only add and subtract can set it
    always_comb begin
        case (ctrl.op)
            isa_pkg::ADD: ovf = (a[MSB] == b[MSB]) && (res[MSB] != a[MSB]);
            isa_pkg::SUB: ovf = (a[MSB] != b[MSB]) && (res[MSB] != a[MSB]);
            default:      ovf = 1'b0;
        endcase
    end

    assign result_o = res;

    always_ff @(posedge clk or negedge rst_ni) begin
        if (!rst_ni) begin
            flag_o <= '0;
        end else if (ctrl.exec && ctrl.alu_en) begin
            flag_o[dp_pkg::FLAG_OVF]   <= ovf;
            flag_o[dp_pkg::FLAG_ZERO]  <= (res[MSB:0] == '0);
            flag_o[dp_pkg::FLAG_CARRY] <= res[DATA_W];
        end
    end

endmodule

// ==== stack_ctrl.sv ====
`timescale 1ns/10ps

module stack_ctrl #(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rst_ni,
    ctrl_if.stk               ctrl,
    input  logic [DATA_W-1:0] data_i,
    input  logic [DATA_W-1:0] push_data_i,
    output logic [DATA_W-1:0] mem_addr_o,
    output logic              mem_we_o,
    output logic [DATA_W-1:0] mem_wdata_o,
    output logic              pop_ok_o,
    output logic              stack_flag_o
);

    logic [DATA_W-1:0] ss_q;
    logic [DATA_W-1:0] sp_q;
    logic              push_req;
    logic              pop_req;
    logic              push_ok;
    logic              pop_ok;
    logic              mov_en;
    logic [DATA_W-1:0] mov_data;

    assign push_req = ctrl.exec && (ctrl.stk_op == dp_pkg::STK_PUSH);
    assign pop_req  = ctrl.exec && (ctrl.stk_op == dp_pkg::STK_POP);
    // full at all ones, empty at zero
    assign push_ok  = push_req && (sp_q != '1);
    assign pop_ok   = pop_req && (sp_q != '0);

    assign mem_addr_o  = push_req ? ss_q + sp_q :
                         pop_req  ? ss_q + sp_q - 1'b1 : '0;
    assign mem_we_o    = push_ok;
    assign mem_wdata_o = push_data_i;
    assign pop_ok_o    = pop_ok;

    // SS and SP load from data_i, or from a register copy
    assign mov_en   = ctrl.exec && (ctrl.wr_src == dp_pkg::WR_DATA ||
                                    ctrl.wr_src == dp_pkg::WR_COPY);
    assign mov_data = (ctrl.wr_src == dp_pkg::WR_DATA) ? data_i : push_data_i;

    always_ff @(posedge clk or negedge rst_ni) begin
        if (!rst_ni) begin
            ss_q         <= '0;
            sp_q         <= '0;
            stack_flag_o <= 1'b0;
        end else begin
            if (mov_en && ctrl.sel_wr == isa_pkg::SEL_R_SS)
                ss_q <= mov_data;
            if (mov_en && ctrl.sel_wr == isa_pkg::SEL_SP_IMM)
                sp_q <= mov_data;
            else if (push_ok)
                sp_q <= sp_q + 1'b1;
            else if (pop_ok)
                sp_q <= sp_q - 1'b1;
            if (push_req || pop_req)
                stack_flag_o <= !(push_ok || pop_ok);
        end
    end

endmodule

// ==== alu_datapath.sv ====
`timescale 1ns/10ps

module alu_datapath (
    input  logic              clk,
    input  logic              rst_ni,
    input  logic              req_i,
    output logic              ack_o,
    input  isa_pkg::opcode_t  op_i,
    input  isa_pkg::reg_sel_t sel1_i,
    input  isa_pkg::reg_sel_t sel2_i,
    input  dp_pkg::word_t     data_i,
    output dp_pkg::word_t     data_o,
    output dp_pkg::flag_t     flag_o,
    output dp_pkg::word_t     mem_addr_o,
    output logic              mem_we_o,
    output dp_pkg::word_t     mem_wdata_o,
    input  dp_pkg::word_t     mem_rdata_i
);

    localparam int DATA_W = dp_pkg::WORD_W;

    dp_pkg::wide_t alu_result;
    dp_pkg::word_t operand_a;
    dp_pkg::word_t operand_b;
    dp_pkg::word_t push_data;
    logic          pop_ok;
    logic          stack_flag;
    logic [2:0]    alu_flag;

    ctrl_if ctrl ();

    op_decoder op_decoder_i (
        .clk    (clk),
        .rst_ni (rst_ni),
        .req_i  (req_i),
        .ack_o  (ack_o),
        .op_i   (op_i),
        .sel1_i (sel1_i),
        .sel2_i (sel2_i),
        .ctrl   (ctrl.dec)
    );

    reg_file #(.DATA_W(DATA_W)) reg_file_i (
        .clk         (clk),
        .rst_ni      (rst_ni),
        .ctrl        (ctrl.regs),
        .data_i      (data_i),
        .result_i    (alu_result),
        .pop_data_i  (mem_rdata_i),
        .pop_ok_i    (pop_ok),
        .operand_a_o (operand_a),
        .operand_b_o (operand_b),
        .push_data_o (push_data),
        .data_o      (data_o)
    );

    alu_unit #(.DATA_W(DATA_W)) alu_unit_i (
        .clk         (clk),
        .rst_ni      (rst_ni),
        .ctrl        (ctrl.alu),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .result_o    (alu_result),
        .flag_o      (alu_flag)
    );

    stack_ctrl #(.DATA_W(DATA_W)) stack_ctrl_i (
        .clk          (clk),
        .rst_ni       (rst_ni),
        .ctrl         (ctrl.stk),
        .data_i       (data_i),
        .push_data_i  (push_data),
        .mem_addr_o   (mem_addr_o),
        .mem_we_o     (mem_we_o),
        .mem_wdata_o  (mem_wdata_o),
        .pop_ok_o     (pop_ok),
        .stack_flag_o (stack_flag)
    );

    assign flag_o[dp_pkg::FLAG_CARRY:dp_pkg::FLAG_OVF] = alu_flag;
    assign flag_o[dp_pkg::FLAG_STACK]                  = stack_flag;

endmodule

// ==== alu_datapath_checker.sv ====
`timescale 1ns/10ps

module alu_datapath_checker (
    input logic clk,
    input logic rst_ni,
    input logic req_i,
    input logic ack_i,
    input logic mem_we_i
);

    int fail_count = 0;

    // ack only answers a request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_ni)
        $rose(ack_i) |-> $past(req_i))
        else begin
            fail_count++;
            $error("ack rose without a pending request");
        end

    // memory writes happen in the exec cycle, which never follows a high ack
    we_not_after_ack: assert property (@(posedge clk) disable iff (!rst_ni)
        mem_we_i |-> !$past(ack_i))
        else begin
            fail_count++;
            $error("memory write in a cycle that followed a high ack");
        end

    ack_low_after_reset: assert property (@(posedge clk) $rose(rst_ni) |=> !ack_i)
        else begin
            fail_count++;
            $error("ack high in the cycle after reset release");
        end

endmodule

bind alu_datapath alu_datapath_checker checker_i (
    .clk      (clk),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .ack_i    (ack_o),
    .mem_we_i (mem_we_o)
);

// ==== tb_alu_datapath.sv ====
`timescale 1ns/10ps

module tb_alu_datapath;

    // roughly 290 handshakes at 5 cycles each, about twice that as the limit
    localparam int MAX_CYCLES = 3000;

    logic              clk;
    logic              rst_ni;
    logic              req_i;
    logic              ack_o;
    isa_pkg::opcode_t  op_i;
    isa_pkg::reg_sel_t sel1_i;
    isa_pkg::reg_sel_t sel2_i;
    dp_pkg::word_t     data_i;
    dp_pkg::word_t     data_o;
    dp_pkg::flag_t     flag_o;
    dp_pkg::word_t     mem_addr_o;
    logic              mem_we_o;
    dp_pkg::word_t     mem_wdata_o;
    dp_pkg::word_t     mem_rdata_i;

    dp_pkg::word_t     stack_mem [65536];
    dp_pkg::word_t     last_waddr;
    dp_pkg::word_t     last_wdata;
    int unsigned       write_count = 0;
    int unsigned       cycle_count = 0;
    logic [31:0]       lfsr_q;
    dp_pkg::flag_t     exp_flags;
    int                err_count = 0;
    int                check_count = 0;

    alu_datapath alu_datapath_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // stack memory, asynchronous read
    assign mem_rdata_i = stack_mem[mem_addr_o];

    always @(posedge clk) begin
        if (mem_we_o) begin
            stack_mem[mem_addr_o] <= mem_wdata_o;
            last_waddr            <= mem_addr_o;
            last_wdata            <= mem_wdata_o;
            write_count           <= write_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("run timed out after %0d cycles, a handshake never completed", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    function automatic dp_pkg::word_t fill_word(input dp_pkg::word_t addr);
        return {addr[7:0], addr[15:8]} ^ 16'h5AC3;
    endfunction

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic rand_word(output dp_pkg::word_t w);
        w = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            w      = {w[14:0], lfsr_q[0]};
        end
    endtask

    function automatic dp_pkg::word_t expect_result(input isa_pkg::opcode_t op,
                                                    input dp_pkg::word_t a,
                                                    input dp_pkg::word_t b);
        case (op)
            isa_pkg::ADD:  return a + b;
            isa_pkg::SUB:  return a - b;
            isa_pkg::AND:  return a & b;
            isa_pkg::OR:   return a | b;
            isa_pkg::NOT:  return ~a;
            isa_pkg::XOR:  return a ^ b;
            isa_pkg::RAND: return (a == 16'hFFFF) ? 16'd1 : 16'd0;
            isa_pkg::ROR:  return (a != 16'd0) ? 16'd1 : 16'd0;
            isa_pkg::RXOR: return dp_pkg::word_t'($countones(a) % 2);
            isa_pkg::LSL:  return a << 1;
            isa_pkg::ASL:  return a << 1;
            isa_pkg::LSR:  return a >> 1;
            isa_pkg::ASR:  return dp_pkg::word_t'($signed(a) >>> 1);
            isa_pkg::CSL:  return (a << 1) | (a >> 15);
            isa_pkg::CSR:  return (a >> 1) | (a << 15);
            isa_pkg::INC:  return a + 16'd1;
            isa_pkg::DEC:  return a - 16'd1;
            default:       return '0;
        endcase
    endfunction

    // returns carry, zero, overflow in flag bit order
    function automatic logic [2:0] expect_flags(input isa_pkg::opcode_t op,
                                                input dp_pkg::word_t a,
                                                input dp_pkg::word_t b);
        int   sum;
        logic ovf;
        logic carry;
        ovf   = 1'b0;
        carry = 1'b0;
        case (op)
            isa_pkg::ADD: begin
                sum   = int'($signed(a)) + int'($signed(b));
                ovf   = (sum > 32767) || (sum < -32768);
                carry = (int'(a) + int'(b)) > 65535;
            end
            isa_pkg::SUB: begin
                sum   = int'($signed(a)) - int'($signed(b));
                ovf   = (sum > 32767) || (sum < -32768);
                carry = a < b;
            end
            isa_pkg::LSL, isa_pkg::ASL: carry = a[15];
            default: ;
        endcase
        return {carry, expect_result(op, a, b) == 16'd0, ovf};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic wait_ack(input logic level);
        do
            @(negedge clk);
        while (ack_o !== level);
    endtask

    // one full four-phase handshake
    task automatic issue_op(input isa_pkg::opcode_t op, input isa_pkg::reg_sel_t s1,
                            input isa_pkg::reg_sel_t s2, input dp_pkg::word_t data);
        @(posedge clk);
        op_i   <= op;
        sel1_i <= s1;
        sel2_i <= s2;
        data_i <= data;
        req_i  <= 1'b1;
        wait_ack(1'b1);
        @(posedge clk);
        req_i <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic write_reg(input isa_pkg::reg_sel_t sel, input dp_pkg::word_t value);
        issue_op(isa_pkg::MOV_AR, isa_pkg::SEL_NONE, sel, value);
    endtask

    task automatic read_reg(input isa_pkg::reg_sel_t sel, output dp_pkg::word_t value);
        issue_op(isa_pkg::MOV_RA, sel, isa_pkg::SEL_NONE, '0);
        value = data_o;
    endtask

    task automatic alu_check(input isa_pkg::opcode_t op, input isa_pkg::reg_sel_t s1,
                             input isa_pkg::reg_sel_t s2, input dp_pkg::word_t a,
                             input dp_pkg::word_t b, input dp_pkg::word_t imm);
        dp_pkg::word_t got;
        issue_op(op, s1, s2, imm);
        exp_flags[dp_pkg::FLAG_CARRY:dp_pkg::FLAG_OVF] = expect_flags(op, a, b);
        read_reg(isa_pkg::SEL_R_SS, got);
        check_value($sformatf("R after %s", op.name()), got, expect_result(op, a, b));
        check_value($sformatf("flag_o after %s", op.name()), flag_o, exp_flags);
    endtask

    task automatic report_test(input string name, input int start);
        $display("test %s finished with %0d errors", name, err_count - start);
    endtask

    task automatic test_reset();
        int            start;
        dp_pkg::word_t got;
        start = err_count;
        check_value("ack_o", ack_o, 0);
        check_value("flag_o", flag_o, 0);
        check_value("data_o", data_o, 0);
        check_value("mem_we_o", mem_we_o, 0);
        read_reg(isa_pkg::SEL_R_SS, got);
        check_value("R", got, 0);
        report_test("reset", start);
    endtask

    task automatic test_arith();
        int            start;
        dp_pkg::word_t a;
        dp_pkg::word_t b;
        start = err_count;
        write_reg(isa_pkg::SEL_D, 16'h0000);
        for (int i = 0; i < 16; i++) begin
            rand_word(a);
            rand_word(b);
            write_reg(isa_pkg::SEL_A, a);
            write_reg(isa_pkg::SEL_B, b);
            alu_check(isa_pkg::ADD, isa_pkg::SEL_A, isa_pkg::SEL_B, a, b, '0);
            alu_check(isa_pkg::SUB, isa_pkg::SEL_A, isa_pkg::SEL_B, a, b, '0);
            alu_check(isa_pkg::DEC, isa_pkg::SEL_D, isa_pkg::SEL_NONE, '0, '0, '0);
        end
        report_test("arithmetic", start);
    endtask

    task automatic test_logic();
        int               start;
        dp_pkg::word_t    a;
        dp_pkg::word_t    b;
        isa_pkg::opcode_t ops [14];
        start = err_count;
        ops = '{isa_pkg::AND, isa_pkg::OR, isa_pkg::NOT, isa_pkg::XOR, isa_pkg::RAND,
                isa_pkg::ROR, isa_pkg::RXOR, isa_pkg::LSL, isa_pkg::LSR, isa_pkg::ASL,
                isa_pkg::ASR, isa_pkg::CSL, isa_pkg::CSR, isa_pkg::INC};
        for (int round = 0; round < 4; round++) begin
            rand_word(a);
            rand_word(b);
            // all ones and all zeros reach the reduction corners
            if (round == 2)
                a = 16'hFFFF;
            if (round == 3)
                a = 16'h0000;
            write_reg(isa_pkg::SEL_A, a);
            write_reg(isa_pkg::SEL_B, b);
            foreach (ops[k])
                alu_check(ops[k], isa_pkg::SEL_A, isa_pkg::SEL_B, a, b, '0);
        end
        report_test("logic and shift", start);
    endtask

    task automatic test_imm();
        int            start;
        dp_pkg::word_t a;
        dp_pkg::word_t imm;
        dp_pkg::word_t got;
        start = err_count;
        rand_word(a);
        rand_word(imm);
        write_reg(isa_pkg::SEL_E, a);
        alu_check(isa_pkg::ADD, isa_pkg::SEL_E, isa_pkg::SEL_SP_IMM, a, imm, imm);
        alu_check(isa_pkg::SUB, isa_pkg::SEL_SP_IMM, isa_pkg::SEL_E, imm, a, imm);
        rand_word(a);
        write_reg(isa_pkg::SEL_F, a);
        issue_op(isa_pkg::LOAD_MOV_RR, isa_pkg::SEL_F, isa_pkg::SEL_C, '0);
        read_reg(isa_pkg::SEL_C, got);
        check_value("C", got, a);
        read_reg(isa_pkg::SEL_F, got);
        check_value("F", got, a);
        report_test("immediate and copy", start);
    endtask

    task automatic test_stack();
        int                start;
        int unsigned       writes;
        dp_pkg::word_t     ss;
        dp_pkg::word_t     got;
        dp_pkg::word_t     vals [4];
        isa_pkg::reg_sel_t pop_sel [4];
        start   = err_count;
        ss      = 16'h1230;
        pop_sel = '{isa_pkg::SEL_E, isa_pkg::SEL_F, isa_pkg::SEL_A, isa_pkg::SEL_B};
        write_reg(isa_pkg::SEL_R_SS, ss);
        write_reg(isa_pkg::SEL_SP_IMM, 16'h0000);
        for (int i = 0; i < 4; i++) begin
            rand_word(vals[i]);
            write_reg(isa_pkg::reg_sel_t'(isa_pkg::SEL_A + i), vals[i]);
        end
        for (int i = 0; i < 4; i++) begin
            issue_op(isa_pkg::PUSH, isa_pkg::reg_sel_t'(isa_pkg::SEL_A + i),
                     isa_pkg::SEL_NONE, '0);
            exp_flags[dp_pkg::FLAG_STACK] = 1'b0;
            check_value("mem_addr_o", last_waddr, dp_pkg::word_t'(ss + i));
            check_value("mem_wdata_o", last_wdata, vals[i]);
            check_value("stack memory", stack_mem[dp_pkg::word_t'(ss + i)], vals[i]);
            check_value("flag_o after push", flag_o, exp_flags);
        end
        for (int i = 0; i < 4; i++) begin
            issue_op(isa_pkg::POP, pop_sel[i], isa_pkg::SEL_NONE, '0);
            check_value("flag_o after pop", flag_o, exp_flags);
            read_reg(pop_sel[i], got);
            check_value("popped word", got, vals[3 - i]);
        end
        // SP is 0 now, so C must keep its value
        issue_op(isa_pkg::POP, isa_pkg::SEL_C, isa_pkg::SEL_NONE, '0);
        exp_flags[dp_pkg::FLAG_STACK] = 1'b1;
        check_value("flag_o after empty pop", flag_o, exp_flags);
        read_reg(isa_pkg::SEL_C, got);
        check_value("C after empty pop", got, vals[2]);
        issue_op(isa_pkg::PUSH, isa_pkg::SEL_D, isa_pkg::SEL_NONE, '0);
        exp_flags[dp_pkg::FLAG_STACK] = 1'b0;
        check_value("flag_o after push", flag_o, exp_flags);
        write_reg(isa_pkg::SEL_SP_IMM, 16'hFFFF);
        writes = write_count;
        issue_op(isa_pkg::PUSH, isa_pkg::SEL_D, isa_pkg::SEL_NONE, '0);
        exp_flags[dp_pkg::FLAG_STACK] = 1'b1;
        check_value("memory writes on full push", write_count, writes);
        check_value("stack memory", stack_mem[ss - 16'd1], fill_word(ss - 16'd1));
        check_value("flag_o after full push", flag_o, exp_flags);
        report_test("stack", start);
    endtask

    task automatic test_backpressure();
        int            start;
        dp_pkg::word_t v;
        dp_pkg::word_t got;
        start = err_count;
        rand_word(v);
        write_reg(isa_pkg::SEL_A, v);
        alu_check(isa_pkg::ADD, isa_pkg::SEL_A, isa_pkg::SEL_NONE, v, '0, '0);
        // INC reads R back, so a repeated execution would add twice
        @(posedge clk);
        op_i   <= isa_pkg::INC;
        sel1_i <= isa_pkg::SEL_R_SS;
        sel2_i <= isa_pkg::SEL_NONE;
        req_i  <= 1'b1;
        wait_ack(1'b1);
        repeat (20) begin
            @(negedge clk);
            check_value("ack_o while req held", ack_o, 1);
        end
        @(posedge clk);
        req_i <= 1'b0;
        @(negedge clk);
        check_value("ack_o before req sampled low", ack_o, 1);
        @(negedge clk);
        check_value("ack_o after req sampled low", ack_o, 0);
        wait_ack(1'b0);
        exp_flags[dp_pkg::FLAG_CARRY:dp_pkg::FLAG_OVF] = expect_flags(isa_pkg::INC, v, '0);
        read_reg(isa_pkg::SEL_R_SS, got);
        check_value("R after held INC", got, v + 16'd1);
        check_value("flag_o after held INC", flag_o, exp_flags);
        report_test("back-pressure", start);
    endtask

    initial begin
        for (int i = 0; i < 65536; i++)
            stack_mem[i] = fill_word(dp_pkg::word_t'(i));
    end

    initial begin
        int total;
        rst_ni    = 1'b0;
        req_i     = 1'b0;
        op_i      = isa_pkg::NO_OP;
        sel1_i    = isa_pkg::SEL_NONE;
        sel2_i    = isa_pkg::SEL_NONE;
        data_i    = '0;
        lfsr_q    = 32'h6705_b800;
        exp_flags = '0;
        repeat (2) @(posedge clk);
        rst_ni <= 1'b1;
        @(negedge clk);
        test_reset();
        test_arith();
        test_logic();
        test_imm();
        test_stack();
        test_backpressure();
        total = err_count + alu_datapath_i.checker_i.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, err_count, alu_datapath_i.checker_i.fail_count);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
isa_pkg.sv
dp_pkg.sv
ctrl_if.sv
op_decoder.sv
reg_file.sv
alu_unit.sv
stack_ctrl.sv
alu_datapath.sv
alu_datapath_checker.sv
tb_alu_datapath.sv

// ==== Bender.yml ====
package:
  name: alu_datapath

sources:
  - isa_pkg.sv
  - dp_pkg.sv
  - ctrl_if.sv
  - op_decoder.sv
  - reg_file.sv
  - alu_unit.sv
  - stack_ctrl.sv
  - alu_datapath.sv
  - target: test
    files:
      - alu_datapath_checker.sv
      - tb_alu_datapath.sv
